//--- list.f
hw/mpu_pkg.sv
hw/pmp_csr_file.sv
hw/pmp_region_match.sv
hw/pmp_priority.sv
hw/mpu_gate.sv
hw/mpu_top.sv
verif/tb_clock_gen.sv
verif/mpu_properties.sv
verif/mpu_tb.sv

//--- Makefile
# Verilator build and run for the MPU testbench

VERILATOR ?= verilator
TOP       ?= mpu_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/mpu_tb.sv
// MPU testbench top: programs regions, drives random requests, models the bus and checks deny
`timescale 1ns/1ps

module mpu_tb;

  localparam int NUM_REGIONS     = 8;
  localparam int MAX_OUTSTANDING = 4;
  localparam int NUM_REQ         = 300;
  localparam int MAX_DELAY       = 4;
  // Two request phases, each request may wait for a full drain
  localparam int WATCHDOG_CYCLES = 2 * NUM_REQ * (MAX_OUTSTANDING * (MAX_DELAY + 1) + 8) + 500;
  // Worst case to empty the bus FIFO model and return a last fault
  localparam int DRAIN_CYCLES    = MAX_OUTSTANDING * (MAX_DELAY + 2) + 16;

  logic                clk;
  logic                rst_n;
  logic                csr_we_i;
  logic [4:0]          csr_sel_i;
  mpu_pkg::pmp_wdata_u csr_wdata_i;
  logic                core_req_valid_i;
  mpu_pkg::mpu_req_t   core_req_i;
  logic                core_req_ready_o;
  logic                core_resp_valid_o;
  mpu_pkg::core_resp_t core_resp_o;
  logic                mpu_err_o;
  logic                bus_req_valid_o;
  mpu_pkg::mpu_req_t   bus_req_o;
  logic                bus_req_ready_i;
  logic                bus_resp_valid_i;
  mpu_pkg::bus_resp_t  bus_resp_i;

  // Reference region state, follows the CSR writes made here
  mpu_pkg::pmp_cfg_t cfg_m [NUM_REGIONS];
  logic [29:0]       addr_m [NUM_REGIONS];

  logic [31:0] stim_seed;
  logic [31:0] bus_seed;
  bit          fault_q [$];
  logic [31:0] resp_data_q [$];
  int          resp_wait_q [$];
  bit          passed;
  bit          fail_seen;

  tb_clock_gen i_clock_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mpu_top #(
    .NUM_REGIONS     (NUM_REGIONS),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .csr_we_i          (csr_we_i),
    .csr_sel_i         (csr_sel_i),
    .csr_wdata_i       (csr_wdata_i),
    .core_req_valid_i  (core_req_valid_i),
    .core_req_i        (core_req_i),
    .core_req_ready_o  (core_req_ready_o),
    .core_resp_valid_o (core_resp_valid_o),
    .core_resp_o       (core_resp_o),
    .mpu_err_o         (mpu_err_o),
    .bus_req_valid_o   (bus_req_valid_o),
    .bus_req_o         (bus_req_o),
    .bus_req_ready_i   (bus_req_ready_i),
    .bus_resp_valid_i  (bus_resp_valid_i),
    .bus_resp_i        (bus_resp_i)
  );

  ////////////////////////////////////////
  // Helpers and reference model
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic fail_stop(input string msg);
    fail_seen = 1'b1;
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  function automatic mpu_pkg::pmp_cfg_t make_cfg(input logic l, input mpu_pkg::pmp_mode_e m,
                                                 input logic x, input logic w, input logic r);
    mpu_pkg::pmp_cfg_t c;
    c.lock = l;
    c.rsvd = 2'b00;
    c.mode = m;
    c.x    = x;
    c.w    = w;
    c.r    = r;
    return c;
  endfunction

  // NAPOT: t trailing ones cover 2^(t+1) words
  function automatic bit napot_hit(input logic [29:0] region, input logic [29:0] word);
    int t;
    t = 0;
    while (t < 30 && region[t]) t++;
    if (t >= 29) return 1'b1;
    return (word >> (t + 1)) == (region >> (t + 1));
  endfunction

  function automatic bit predict_deny(input mpu_pkg::mpu_req_t req);
    logic [29:0] word;
    logic [29:0] lo;
    bit          hit;
    bit          perm;
    bit          user;
    word = req.addr[31:2];
    user = (req.priv == mpu_pkg::PRIV_U);
    for (int i = 0; i < NUM_REGIONS; i++) begin
      lo = (i == 0) ? 30'd0 : addr_m[i-1];
      case (cfg_m[i].mode)
        mpu_pkg::TOR:   hit = (word >= lo) && (word < addr_m[i]);
        mpu_pkg::NA4:   hit = (word == addr_m[i]);
        mpu_pkg::NAPOT: hit = napot_hit(addr_m[i], word);
        default:        hit = 1'b0;
      endcase
      if (hit) begin
        perm = (req.acc == mpu_pkg::ACC_READ)  ? cfg_m[i].r :
               (req.acc == mpu_pkg::ACC_WRITE) ? cfg_m[i].w : cfg_m[i].x;
        return (cfg_m[i].lock || user) ? !perm : 1'b0;
      end
    end
    // Nothing matched
    return user;
  endfunction

  // One-cycle strobe, model updated once the registers have taken it
  task automatic csr_write(input logic [4:0] sel, input logic [31:0] data);
    int r;
    csr_we_i    <= 1'b1;
    csr_sel_i   <= sel;
    csr_wdata_i <= data;
    @(posedge clk);
    csr_we_i <= 1'b0;
    @(posedge clk);
    if (sel[4]) begin
      r = int'(sel[3:0]);
      if (r < NUM_REGIONS && !cfg_m[r].lock) addr_m[r] = data[31:2];
    end else begin
      for (int b = 0; b < 4; b++) begin
        r = int'(sel[3:0]) * 4 + b;
        if (r < NUM_REGIONS && !cfg_m[r].lock) cfg_m[r] = data[8*b +: 8];
      end
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Overlapping layout so that lower index priority matters
  task automatic program_regions();
    logic [29:0] addrs [NUM_REGIONS];
    addrs = '{30'h400, 30'h5FF, 30'h800, 30'hC00, 30'h7FF, 30'h1000, 30'h1400, 30'h0};
    for (int i = 0; i < NUM_REGIONS; i++) begin
      csr_write(5'h10 | 5'(i), {addrs[i], 2'b00});
    end
    csr_write(5'd0, {make_cfg(0, mpu_pkg::TOR, 1, 0, 0), make_cfg(0, mpu_pkg::OFF, 1, 1, 1),
                     make_cfg(0, mpu_pkg::NAPOT, 0, 1, 1), make_cfg(0, mpu_pkg::NA4, 0, 0, 1)});
    csr_write(5'd1, {make_cfg(0, mpu_pkg::OFF, 0, 0, 0), make_cfg(0, mpu_pkg::TOR, 0, 0, 1),
                     make_cfg(0, mpu_pkg::OFF, 0, 0, 0), make_cfg(0, mpu_pkg::NAPOT, 1, 1, 1)});
  endtask

  // Lock region 1 read-only, then try to reopen it
  task automatic lock_region_one();
    csr_write(5'd0, {make_cfg(0, mpu_pkg::TOR, 1, 0, 0), make_cfg(0, mpu_pkg::OFF, 1, 1, 1),
                     make_cfg(1, mpu_pkg::NAPOT, 0, 0, 1), make_cfg(0, mpu_pkg::NA4, 0, 0, 1)});
    csr_write(5'd0, {make_cfg(0, mpu_pkg::TOR, 1, 0, 0), make_cfg(0, mpu_pkg::OFF, 1, 1, 1),
                     make_cfg(0, mpu_pkg::NAPOT, 1, 1, 1), make_cfg(0, mpu_pkg::NA4, 0, 0, 1)});
    csr_write(5'h11, 32'h0000_FFFC);
  endtask

  task automatic run_requests(input int n);
    mpu_pkg::mpu_req_t req;
    for (int k = 0; k < n; k++) begin
      stim_seed = xorshift32(stim_seed);
      if (stim_seed[2:0] == 3'd0) begin
        core_req_valid_i <= 1'b0;
        @(posedge clk);
      end
      // Mostly inside the programmed window, sometimes anywhere
      req.addr  = (stim_seed[31:30] == 2'd0) ? (stim_seed & 32'hFFFF_FFFC) : (stim_seed & 32'h7FFC);
      stim_seed = xorshift32(stim_seed);
      req.wdata = stim_seed;
      req.acc   = mpu_pkg::mpu_acc_e'(2'(stim_seed % 3));
      req.priv  = mpu_pkg::mpu_priv_e'(stim_seed[7]);
      core_req_valid_i <= 1'b1;
      core_req_i       <= req;
      do @(posedge clk); while (!core_req_ready_o);
    end
    core_req_valid_i <= 1'b0;
  endtask

  initial begin
    int drain;
    csr_we_i         = 1'b0;
    csr_sel_i        = '0;
    csr_wdata_i      = '0;
    core_req_valid_i = 1'b0;
    core_req_i       = '0;
    stim_seed        = 32'he773;
    // Regions come out of reset OFF and unlocked
    for (int i = 0; i < NUM_REGIONS; i++) begin
      cfg_m[i]  = '0;
      addr_m[i] = '0;
    end
    @(posedge rst_n);
    @(posedge clk);
    program_regions();
    run_requests(NUM_REQ);
    lock_region_one();
    run_requests(NUM_REQ);
    // Bounded wait for the last faults and bus responses
    drain = 0;
    @(negedge clk);
    while ((fault_q.size() != 0 || resp_wait_q.size() != 0) && drain < DRAIN_CYCLES) begin
      @(negedge clk);
      drain++;
    end
    repeat (4) @(posedge clk);
    if (fault_q.size() != 0 || resp_wait_q.size() != 0) begin
      fail_stop("Requests still pending at end of run");
    end else begin
      passed = 1'b1;
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Bus responder, in order, random delay
  ////////////////////////////////////////

  initial begin
    bus_req_ready_i  = 1'b0;
    bus_resp_valid_i = 1'b0;
    bus_resp_i       = '0;
    bus_seed         = 32'he773 ^ 32'h5A5A_0000;
    forever begin
      @(posedge clk);
      bus_resp_valid_i <= 1'b0;
      if (resp_wait_q.size() != 0) begin
        if (resp_wait_q[0] == 0) begin
          bus_resp_valid_i <= 1'b1;
          bus_resp_i.rdata <= resp_data_q.pop_front();
          bus_resp_i.err   <= bus_seed[9] & bus_seed[10];
          void'(resp_wait_q.pop_front());
        end else begin
          resp_wait_q[0] = resp_wait_q[0] - 1;
        end
      end
      bus_seed = xorshift32(bus_seed);
      if (bus_req_valid_o && bus_req_ready_i) begin
        resp_data_q.push_back(bus_seed);
        resp_wait_q.push_back(int'(bus_seed[17:16]));
      end
      bus_req_ready_i <= (bus_seed[23:20] > 4'd4);
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Deny decision, sampled mid-cycle
  always @(negedge clk) begin
    bit exp_deny;
    if (rst_n && core_req_valid_i) begin
      exp_deny = predict_deny(core_req_i);
      if (mpu_err_o !== exp_deny) begin
        fail_stop($sformatf("ERROR %0t mpu_err_o expected %0b got %0b", $time, exp_deny,
                            mpu_err_o));
      end
    end
  end

  // One fault per accepted denied request, type from the access
  always @(posedge clk) begin
    mpu_pkg::mpu_status_e exp_st;
    if (rst_n && core_resp_valid_o && core_resp_o.mpu_status != mpu_pkg::MPU_OK) begin
      if (fault_q.size() == 0) begin
        fail_stop("Fault response without a denied request");
      end else begin
        exp_st = fault_q.pop_front() ? mpu_pkg::MPU_WR_FAULT : mpu_pkg::MPU_RE_FAULT;
        if (core_resp_o.mpu_status != exp_st) begin
          fail_stop($sformatf("ERROR %0t core_resp_o.mpu_status expected %0d got %0d", $time,
                              exp_st, core_resp_o.mpu_status));
        end
      end
    end
    if (rst_n && core_req_valid_i && core_req_ready_o && mpu_err_o) begin
      fault_q.push_back(core_req_i.acc == mpu_pkg::ACC_WRITE);
    end
  end

  initial begin
    passed    = 1'b0;
    fail_seen = 1'b0;
    #(WATCHDOG_CYCLES * 10);
    fail_stop("Watchdog expired, the run did not complete in time");
  end

  // Run stopped by a failing assertion
  final begin
    if (!passed && !fail_seen) $display("*** TEST FAILED ***");
  end

endmodule

//--- verif/mpu_properties.sv
// Gate protocol assertions, bound into every mpu_gate instance from this file
`timescale 1ns/1ps

module mpu_properties #(
  parameter int MAX_OUTSTANDING = 4
) (
  input logic                                     clk,
  input logic                                     rst_n,
  input logic                                     core_req_valid_i,
  input mpu_pkg::mpu_req_t                        core_req_i,
  input logic                                     core_req_ready_o,
  input logic                                     mpu_err_o,
  input logic                                     bus_req_valid_o,
  input mpu_pkg::mpu_req_t                        bus_req_o,
  input logic                                     bus_req_ready_i,
  input logic                                     bus_resp_valid_i,
  input mpu_pkg::bus_resp_t                       bus_resp_i,
  input logic                                     core_resp_valid_o,
  input mpu_pkg::core_resp_t                      core_resp_o,
  input mpu_pkg::mpu_state_e                      state_q,
  input logic [$clog2(MAX_OUTSTANDING+1)-1:0]     outstanding_q
);

  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  logic fault_resp;
  logic can_issue;

  assign fault_resp = core_resp_valid_o && (core_resp_o.mpu_status != mpu_pkg::MPU_OK);
  // Idle gate with room for one more transaction
  assign can_issue  = (state_q == mpu_pkg::MPU_IDLE) && (outstanding_q < CNT_W'(MAX_OUTSTANDING));

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  // Denied or pending-fault requests stay off the bus
  a_no_bus_on_deny: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_valid_o |-> (!mpu_err_o && (state_q == mpu_pkg::MPU_IDLE)))
    else $error("bus request issued while denied or fault pending");

  // Allowed request goes out unchanged
  a_forward: assert property (@(posedge clk) disable iff (!rst_n)
    (core_req_valid_i && !mpu_err_o && can_issue) |-> (bus_req_valid_o && (bus_req_o == core_req_i)))
    else $error("allowed request not forwarded unchanged");

  // Ready follows the bus for forwarded requests
  // Denied request in idle is taken at once
  a_ready: assert property (@(posedge clk) disable iff (!rst_n)
    core_req_valid_i |-> (core_req_ready_o ==
                          ((can_issue && bus_req_ready_i) ||
                           (mpu_err_o && (state_q == mpu_pkg::MPU_IDLE)))))
    else $error("core ready does not follow bus ready and deny");

  a_cnt_limit: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding_q <= CNT_W'(MAX_OUTSTANDING))
    else $error("outstanding count above limit");

  ////////////////////////////////////////
  // Response side
  ////////////////////////////////////////

  // Fault only after all earlier bus work has drained
  a_fault_drained: assert property (@(posedge clk) disable iff (!rst_n)
    fault_resp |-> (outstanding_q == '0))
    else $error("fault response with transactions in flight");

  a_resp_pass: assert property (@(posedge clk) disable iff (!rst_n)
    bus_resp_valid_i |-> (core_resp_valid_o && (core_resp_o.mpu_status == mpu_pkg::MPU_OK) &&
                          (core_resp_o.rdata == bus_resp_i.rdata) &&
                          (core_resp_o.bus_err == bus_resp_i.err)))
    else $error("bus response not passed to core");

  // Quiet outputs while reset is held
  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> (!bus_req_valid_o && !core_resp_valid_o && !mpu_err_o))
    else $error("outputs active during reset");

endmodule

bind mpu_gate mpu_properties #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) i_props (
  .clk               (clk),
  .rst_n             (rst_n),
  .core_req_valid_i  (core_req_valid_i),
  .core_req_i        (core_req_i),
  .core_req_ready_o  (core_req_ready_o),
  .mpu_err_o         (mpu_err_o),
  .bus_req_valid_o   (bus_req_valid_o),
  .bus_req_o         (bus_req_o),
  .bus_req_ready_i   (bus_req_ready_i),
  .bus_resp_valid_i  (bus_resp_valid_i),
  .bus_resp_i        (bus_resp_i),
  .core_resp_valid_o (core_resp_valid_o),
  .core_resp_o       (core_resp_o),
  .state_q           (state_q),
  .outstanding_q     (outstanding_q)
);

//--- verif/tb_clock_gen.sv
// Testbench clock and reset source: 10 ns clock, active-low reset held for two cycles
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset released on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- hw/mpu_top.sv
// MPU top level: CSR file, per-region matchers, priority resolver and request gate
`timescale 1ns/1ps

module mpu_top #(
  parameter int NUM_REGIONS     = 8,
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  // CSR write port
  input  logic                csr_we_i,
  input  logic [4:0]          csr_sel_i,
  input  mpu_pkg::pmp_wdata_u csr_wdata_i,
  // Core side
  input  logic                core_req_valid_i,
  input  mpu_pkg::mpu_req_t   core_req_i,
  output logic                core_req_ready_o,
  output logic                core_resp_valid_o,
  output mpu_pkg::core_resp_t core_resp_o,
  output logic                mpu_err_o,
  // Bus side
  output logic                bus_req_valid_o,
  output mpu_pkg::mpu_req_t   bus_req_o,
  input  logic                bus_req_ready_i,
  input  logic                bus_resp_valid_i,
  input  mpu_pkg::bus_resp_t  bus_resp_i
);

  mpu_pkg::pmp_cfg_t [NUM_REGIONS-1:0] region_cfg;
  logic [NUM_REGIONS-1:0][29:0]        region_addr;
  logic [NUM_REGIONS-1:0]              region_match;
  logic [NUM_REGIONS-1:0]              region_perm_ok;
  logic [NUM_REGIONS-1:0]              region_lock;
  logic                                pmp_deny;

  pmp_csr_file #(.NUM_REGIONS(NUM_REGIONS)) i_csr_file (
    .clk         (clk),
    .rst_n       (rst_n),
    .csr_we_i    (csr_we_i),
    .csr_sel_i   (csr_sel_i),
    .csr_wdata_i (csr_wdata_i),
    .cfg_o       (region_cfg),
    .addr_o      (region_addr)
  );

  ////////////////////////////////////////
  // Region matchers
  ////////////////////////////////////////

  for (genvar g = 0; g < NUM_REGIONS; g++) begin : g_region
    logic [29:0] addr_below;

    // TOR lower bound, region 0 starts at address zero
    if (g == 0) begin : g_first
      assign addr_below = '0;
    end else begin : g_rest
      assign addr_below = region_addr[g-1];
    end

    assign region_lock[g] = region_cfg[g].lock;

    pmp_region_match i_match (
      .cfg_i        (region_cfg[g]),
      .addr_i       (region_addr[g]),
      .addr_below_i (addr_below),
      .req_addr_i   (core_req_i.addr),
      .acc_i        (core_req_i.acc),
      .match_o      (region_match[g]),
      .perm_ok_o    (region_perm_ok[g])
    );
  end

  pmp_priority #(.NUM_REGIONS(NUM_REGIONS)) i_priority (
    .match_i    (region_match),
    .perm_ok_i  (region_perm_ok),
    .lock_i     (region_lock),
    .priv_i     (core_req_i.priv),
    .pmp_deny_o (pmp_deny)
  );

  mpu_gate #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) i_gate (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_req_valid_i  (core_req_valid_i),
    .core_req_i        (core_req_i),
    .core_req_ready_o  (core_req_ready_o),
    .pmp_deny_i        (pmp_deny),
    .bus_req_valid_o   (bus_req_valid_o),
    .bus_req_o         (bus_req_o),
    .bus_req_ready_i   (bus_req_ready_i),
    .bus_resp_valid_i  (bus_resp_valid_i),
    .bus_resp_i        (bus_resp_i),
    .core_resp_valid_o (core_resp_valid_o),
    .core_resp_o       (core_resp_o),
    .mpu_err_o         (mpu_err_o)
  );

endmodule

//--- hw/mpu_gate.sv
// Request gate: forwards allowed requests, consumes denied ones and returns the fault response
`timescale 1ns/1ps

module mpu_gate #(
  parameter int MAX_OUTSTANDING = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  // Core request
  input  logic                core_req_valid_i,
  input  mpu_pkg::mpu_req_t   core_req_i,
  output logic                core_req_ready_o,
  // Decision from the resolver
  input  logic                pmp_deny_i,
  // Bus request
  output logic                bus_req_valid_o,
  output mpu_pkg::mpu_req_t   bus_req_o,
  input  logic                bus_req_ready_i,
  // Bus response, in request order
  input  logic                bus_resp_valid_i,
  input  mpu_pkg::bus_resp_t  bus_resp_i,
  // Core response, core is always ready
  output logic                core_resp_valid_o,
  output mpu_pkg::core_resp_t core_resp_o,
  output logic                mpu_err_o
);

  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  mpu_pkg::mpu_state_e state_q, state_d;

  // Bus requests accepted but not yet answered
  logic [CNT_W-1:0] outstanding_q;
  logic             cnt_full;
  logic             bus_acc;

  // Denied access was a write
  logic err_wr_q;
  logic err_wr_d;

  logic block_bus;
  logic block_core;
  logic err_accept;
  logic err_resp;

  assign cnt_full = (outstanding_q == CNT_W'(MAX_OUTSTANDING));

  ////////////////////////////////////////
  // Error FSM
  ////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    err_wr_d   = err_wr_q;
    block_bus  = 1'b0;
    block_core = 1'b0;
    err_accept = 1'b0;
    err_resp   = 1'b0;
    case (state_q)
      mpu_pkg::MPU_IDLE: begin
        // Full counter stalls new bus traffic
        block_bus  = cnt_full;
        block_core = cnt_full;
        if (core_req_valid_i && pmp_deny_i) begin
          // Consume the request without touching the bus
          block_bus  = 1'b1;
          err_accept = 1'b1;
          err_wr_d   = (core_req_i.acc == mpu_pkg::ACC_WRITE);
          state_d    = mpu_pkg::MPU_ERR_WAIT;
        end
      end
      mpu_pkg::MPU_ERR_WAIT: begin
        block_bus  = 1'b1;
        block_core = 1'b1;
        // Earlier transactions drain first
        if (outstanding_q == '0) begin
          state_d = mpu_pkg::MPU_ERR_RESP;
        end
      end
      mpu_pkg::MPU_ERR_RESP: begin
        block_bus  = 1'b1;
        block_core = 1'b1;
        err_resp   = 1'b1;
        state_d    = mpu_pkg::MPU_IDLE;
      end
      default: begin
        state_d = mpu_pkg::MPU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= mpu_pkg::MPU_IDLE;
      err_wr_q      <= 1'b0;
      outstanding_q <= '0;
    end else begin
      state_q  <= state_d;
      err_wr_q <= err_wr_d;
      // Simultaneous issue and response leave the count unchanged
      if (bus_acc && !bus_resp_valid_i) begin
        outstanding_q <= outstanding_q + 1'b1;
      end else if (!bus_acc && bus_resp_valid_i) begin
        outstanding_q <= outstanding_q - 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Request and response paths
  ////////////////////////////////////////

  assign bus_req_valid_o  = core_req_valid_i && !block_bus;
  assign bus_req_o        = core_req_i;
  assign bus_acc          = bus_req_valid_o && bus_req_ready_i;
  // Denied request is taken regardless of bus back-pressure
  assign core_req_ready_o = (bus_req_ready_i && !block_core) || err_accept;
  assign mpu_err_o        = core_req_valid_i && pmp_deny_i;

  assign core_resp_valid_o = bus_resp_valid_i || err_resp;

  always_comb begin
    core_resp_o.rdata      = bus_resp_i.rdata;
    core_resp_o.bus_err    = bus_resp_i.err;
    core_resp_o.mpu_status = mpu_pkg::MPU_OK;
    if (err_resp) begin
      core_resp_o.rdata      = '0;
      core_resp_o.bus_err    = 1'b0;
      core_resp_o.mpu_status = err_wr_q ? mpu_pkg::MPU_WR_FAULT : mpu_pkg::MPU_RE_FAULT;
    end
  end

endmodule

//--- hw/pmp_priority.sv
// Resolves the per-region match results into a single deny for the current request
`timescale 1ns/1ps

module pmp_priority #(
  parameter int NUM_REGIONS = 8
) (
  input  logic [NUM_REGIONS-1:0] match_i,
  input  logic [NUM_REGIONS-1:0] perm_ok_i,
  input  logic [NUM_REGIONS-1:0] lock_i,
  input  mpu_pkg::mpu_priv_e     priv_i,
  output logic                   pmp_deny_o
);

  // Winning region attributes
  logic hit;
  logic hit_perm;
  logic hit_lock;
  logic user_mode;

  assign user_mode = (priv_i == mpu_pkg::PRIV_U);

  // Scan downwards so the lowest matching index is the last to write
  always_comb begin
    hit      = 1'b0;
    hit_perm = 1'b0;
    hit_lock = 1'b0;
    for (int i = NUM_REGIONS - 1; i >= 0; i--) begin
      if (match_i[i]) begin
        hit      = 1'b1;
        hit_perm = perm_ok_i[i];
        hit_lock = lock_i[i];
      end
    end
  end

  // No match: machine mode passes, user mode fails
  // Locked region or user mode: permission bit decides
  assign pmp_deny_o = !hit ? user_mode :
                      (hit_lock || user_mode) ? !hit_perm : 1'b0;

endmodule

//--- hw/pmp_region_match.sv
// Address match and permission lookup for a single region, one instance per region
`timescale 1ns/1ps

module pmp_region_match (
  input  mpu_pkg::pmp_cfg_t cfg_i,
  input  logic [29:0]       addr_i,
  input  logic [29:0]       addr_below_i,
  input  logic [31:0]       req_addr_i,
  input  mpu_pkg::mpu_acc_e acc_i,
  output logic              match_o,
  output logic              perm_ok_o
);

  // Granularity is one word, so only address bits 31:2 take part
  logic [29:0] req_word;

  // NAPOT size mask, zero over the bits covered by the region
  logic [29:0] napot_mask;

  assign req_word = req_addr_i[31:2];

  // addr ^ (addr + 1) sets the trailing ones plus the first zero
  // e.g. ...0111 covers 16 words, all ones covers the whole space
  assign napot_mask = ~(addr_i ^ (addr_i + 30'd1));

  ////////////////////////////////////////
  // Mode decode
  ////////////////////////////////////////

  always_comb begin
    match_o = 1'b0;
    case (cfg_i.mode)
      mpu_pkg::TOR: begin
        // Range from the region below, top excluded
        match_o = (req_word >= addr_below_i) && (req_word < addr_i);
      end
      mpu_pkg::NA4: begin
        match_o = (req_word == addr_i);
      end
      mpu_pkg::NAPOT: begin
        match_o = ((req_word & napot_mask) == (addr_i & napot_mask));
      end
      default: begin
        // Region is OFF
        match_o = 1'b0;
      end
    endcase
  end

  // Permission bit for this access, lock is applied by the resolver
  always_comb begin
    case (acc_i)
      mpu_pkg::ACC_READ:  perm_ok_o = cfg_i.r;
      mpu_pkg::ACC_WRITE: perm_ok_o = cfg_i.w;
      mpu_pkg::ACC_EXEC:  perm_ok_o = cfg_i.x;
      default:            perm_ok_o = 1'b0;
    endcase
  end

endmodule

//--- hw/pmp_csr_file.sv
// Region configuration and address registers, updated by a one-cycle CSR write strobe
`timescale 1ns/1ps

module pmp_csr_file #(
  parameter int NUM_REGIONS = 8
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   csr_we_i,
  input  logic [4:0]                             csr_sel_i,
  input  mpu_pkg::pmp_wdata_u                    csr_wdata_i,
  output mpu_pkg::pmp_cfg_t [NUM_REGIONS-1:0]    cfg_o,
  output logic [NUM_REGIONS-1:0][29:0]           addr_o
);

  mpu_pkg::pmp_cfg_t [NUM_REGIONS-1:0] cfg_q;
  logic [NUM_REGIONS-1:0][29:0]        addr_q;

  // Decoded write strobes
  logic cfg_we;
  logic addr_we;

  // Top select bit picks the view of the write word
  assign cfg_we  = csr_we_i && !csr_sel_i[4];
  assign addr_we = csr_we_i && csr_sel_i[4];

  ////////////////////////////////////////
  // Configuration bytes
  ////////////////////////////////////////

  // Word n holds regions 4n to 4n+3, byte 0 is the lowest region
  // A set lock bit blocks its own byte, so it stays set until reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q <= '0;
    end else begin
      for (int r = 0; r < NUM_REGIONS; r++) begin
        if (cfg_we && (csr_sel_i[3:0] == 4'(r / 4)) && !cfg_q[r].lock) begin
          cfg_q[r] <= csr_wdata_i.cfg[r % 4];
        end
      end
    end
  end

  ////////////////////////////////////////
  // Address registers
  ////////////////////////////////////////

  // Address bits 31:2, ignored while the region is locked
  always_ff @(posedge clk) begin
    for (int r = 0; r < NUM_REGIONS; r++) begin
      if (addr_we && (csr_sel_i[3:0] == 4'(r)) && !cfg_q[r].lock) begin
        addr_q[r] <= csr_wdata_i.addr_w.addr;
      end
    end
  end

  assign cfg_o  = cfg_q;
  assign addr_o = addr_q;

endmodule

//--- hw/mpu_pkg.sv
// Shared types for the MPU; every design file refers to them as mpu_pkg::name
package mpu_pkg;

  ////////////////////////////////////////
  // Request side encodings
  ////////////////////////////////////////

  // Access type of a core request
  typedef enum logic [1:0] {
    ACC_READ  = 2'd0,
    ACC_WRITE = 2'd1,
    ACC_EXEC  = 2'd2
  } mpu_acc_e;

  // Privilege of the requester
  typedef enum logic {
    PRIV_U = 1'b0,
    PRIV_M = 1'b1
  } mpu_priv_e;

  // Address matching mode of one region
  typedef enum logic [1:0] {
    OFF   = 2'd0,
    TOR   = 2'd1,
    NA4   = 2'd2,
    NAPOT = 2'd3
  } pmp_mode_e;

  // One region configuration byte, lock bit on top
  typedef struct packed {
    logic      lock;
    logic [1:0] rsvd;
    pmp_mode_e mode;
    logic      x;
    logic      w;
    logic      r;
  } pmp_cfg_t;

  // Core request payload, also forwarded unchanged to the bus
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    mpu_acc_e    acc;
    mpu_priv_e   priv;
  } mpu_req_t;

  // Bus response payload
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } bus_resp_t;

  ////////////////////////////////////////
  // Response side and gate FSM
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    MPU_OK       = 2'd0,
    MPU_RE_FAULT = 2'd1,
    MPU_WR_FAULT = 2'd2
  } mpu_status_e;

  // Response towards the core
  typedef struct packed {
    logic [31:0] rdata;
    logic        bus_err;
    mpu_status_e mpu_status;
  } core_resp_t;

  typedef enum logic [1:0] {
    MPU_IDLE     = 2'd0,
    MPU_ERR_WAIT = 2'd1,
    MPU_ERR_RESP = 2'd2
  } mpu_state_e;

  // CSR write word, either four cfg bytes or one region address
  typedef union packed {
    pmp_cfg_t [3:0] cfg;
    struct packed {
      logic [29:0] addr;
      logic [1:0]  zero;
    } addr_w;
  } pmp_wdata_u;

endpackage
